/* Makefile */
VERILATOR ?= verilator
TOP       ?= bmu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run check clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/bmu_tb.sv */
// one target of the data bus, with a random grant wait and a random completion latency
module dbus_responder (
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  output logic        grnt = 1'b0,
  output logic [31:0] data = '0,
  output logic        data_vld = 1'b0,
  output logic        acc_err = 1'b0,
  output logic        trans_cmplt = 1'b0
);

  int   seed = 16;
  logic busy = 1'b0;
  int   wait_cnt = 0;
  int   lat_cnt = 0;

  function automatic int rand_below(int n);
    return {$random(seed)} % n;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      grnt        <= 1'b0;
      busy        <= 1'b0;
      trans_cmplt <= 1'b0;
      data_vld    <= 1'b0;
      acc_err     <= 1'b0;
      wait_cnt    <= 0;
    end else begin
      trans_cmplt <= 1'b0;
      data_vld    <= 1'b0;
      acc_err     <= 1'b0;
      if (busy) begin
        if (lat_cnt == 1) begin
          busy        <= 1'b0;
          grnt        <= 1'b0;
          trans_cmplt <= 1'b1;
          data        <= $random(seed);
          data_vld    <= (rand_below(2) == 0);
          acc_err     <= (rand_below(8) == 0);
          wait_cnt    <= rand_below(4);
        end else begin
          lat_cnt <= lat_cnt - 1;
        end
      end else if (req && grnt) begin
        busy    <= 1'b1;
        grnt    <= 1'b0;
        lat_cnt <= 1 + rand_below(6);
      end else if (req) begin
        // the wait only runs down while a request is actually held
        grnt <= (wait_cnt <= 1);
        if (wait_cnt > 0) begin
          wait_cnt <= wait_cnt - 1;
        end
      end else begin
        grnt <= (wait_cnt == 0);
      end
    end
  end

endmodule

module bmu_tb;

  import bmu_map_pkg::*;

  localparam int n_req = 400;
  localparam int max_cycles = n_req * 16 + 200;

  logic        forever_cpuclk, rst;
  logic [11:0] pad_bmu_iahbl_base, pad_bmu_iahbl_mask;
  logic        lsu_bmu_req, lsu_bmu_write, lsu_bmu_addr_check_fail;
  logic [31:0] lsu_bmu_addr, lsu_bmu_wdata;
  logic [1:0]  lsu_bmu_size;
  logic [3:0]  lsu_bmu_prot;
  logic        bmu_lsu_grnt, bmu_lsu_data_vld, bmu_lsu_acc_err, bmu_lsu_trans_cmplt;
  logic [31:0] bmu_lsu_data;
  logic        bmu_biu_dbus_req, bmu_iahbl_dbus_req, bmu_tcipif_dbus_req;
  logic        bmu_biu_dbus_write, bmu_iahbl_dbus_write, bmu_tcipif_dbus_write;
  logic [31:0] bmu_biu_dbus_addr, bmu_iahbl_dbus_addr, bmu_tcipif_dbus_addr;
  logic [31:0] bmu_biu_dbus_wdata, bmu_iahbl_dbus_wdata, bmu_tcipif_dbus_wdata;
  logic [1:0]  bmu_biu_dbus_size, bmu_iahbl_dbus_size, bmu_tcipif_dbus_size;
  logic [3:0]  bmu_biu_dbus_prot, bmu_iahbl_dbus_prot;
  logic        bmu_tcipif_dbus_supv_mode;
  logic        biu_bmu_dbus_grnt, biu_bmu_dbus_data_vld;
  logic        biu_bmu_dbus_acc_err, biu_bmu_dbus_trans_cmplt;
  logic        iahbl_bmu_dbus_grnt, iahbl_bmu_dbus_data_vld;
  logic        iahbl_bmu_dbus_acc_err, iahbl_bmu_dbus_trans_cmplt;
  logic        tcipif_bmu_dbus_grnt, tcipif_bmu_dbus_data_vld;
  logic        tcipif_bmu_dbus_acc_err, tcipif_bmu_dbus_trans_cmplt;
  logic [31:0] biu_bmu_dbus_data, iahbl_bmu_dbus_data, tcipif_bmu_dbus_data;

  int          seed = 16;
  int          errors = 0;
  int          checks = 0;
  int          issued = 0;
  int          granted = 0;
  int          cycles = 0;
  logic        grant_seen = 1'b0;
  logic        m_out = 1'b0;
  logic        m_deny = 1'b0;
  bmu_target_e m_tgt = tgt_biu;

  bmu_top bmu_top_inst (.*);

  dbus_responder biu_responder (
    .clk         (forever_cpuclk),
    .rst         (rst),
    .req         (bmu_biu_dbus_req),
    .grnt        (biu_bmu_dbus_grnt),
    .data        (biu_bmu_dbus_data),
    .data_vld    (biu_bmu_dbus_data_vld),
    .acc_err     (biu_bmu_dbus_acc_err),
    .trans_cmplt (biu_bmu_dbus_trans_cmplt)
  );

  dbus_responder iahbl_responder (
    .clk         (forever_cpuclk),
    .rst         (rst),
    .req         (bmu_iahbl_dbus_req),
    .grnt        (iahbl_bmu_dbus_grnt),
    .data        (iahbl_bmu_dbus_data),
    .data_vld    (iahbl_bmu_dbus_data_vld),
    .acc_err     (iahbl_bmu_dbus_acc_err),
    .trans_cmplt (iahbl_bmu_dbus_trans_cmplt)
  );

  dbus_responder tcipif_responder (
    .clk         (forever_cpuclk),
    .rst         (rst),
    .req         (bmu_tcipif_dbus_req),
    .grnt        (tcipif_bmu_dbus_grnt),
    .data        (tcipif_bmu_dbus_data),
    .data_vld    (tcipif_bmu_dbus_data_vld),
    .acc_err     (tcipif_bmu_dbus_acc_err),
    .trans_cmplt (tcipif_bmu_dbus_trans_cmplt)
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever #4 forever_cpuclk = ~forever_cpuclk;
  end

  function automatic int rand_below(int n);
    return {$random(seed)} % n;
  endfunction

  task automatic report_error(string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  // private segment first, then the pin window on the top 12 bits, else the system bus
  function automatic bmu_target_e expect_target(logic [31:0] a);
    if (a[31:28] == 4'he) begin
      return tgt_tcip;
    end
    if ((a[31:20] & pad_bmu_iahbl_mask) == (pad_bmu_iahbl_base & pad_bmu_iahbl_mask)) begin
      return tgt_iahbl;
    end
    return tgt_biu;
  endfunction

  function automatic logic expect_deny(logic [31:0] a, logic [1:0] sz, logic [3:0] pr,
                                       logic fail);
    logic bad;
    case (sz)
      2'd0:    bad = 1'b0;
      2'd1:    bad = a[0];
      2'd2:    bad = (a[1:0] != 2'b00);
      default: bad = 1'b1;
    endcase
    return bad || (!pr[1] && a[31:28] == 4'he) || fail;
  endfunction

  // grnt, trans_cmplt, data_vld, acc_err and data as the responder drives them
  function automatic logic [35:0] target_response(bmu_target_e tgt);
    case (tgt)
      tgt_biu: return {biu_bmu_dbus_grnt, biu_bmu_dbus_trans_cmplt, biu_bmu_dbus_data_vld,
                       biu_bmu_dbus_acc_err, biu_bmu_dbus_data};
      tgt_iahbl: return {iahbl_bmu_dbus_grnt, iahbl_bmu_dbus_trans_cmplt,
                         iahbl_bmu_dbus_data_vld, iahbl_bmu_dbus_acc_err, iahbl_bmu_dbus_data};
      tgt_tcip: return {tcipif_bmu_dbus_grnt, tcipif_bmu_dbus_trans_cmplt,
                        tcipif_bmu_dbus_data_vld, tcipif_bmu_dbus_acc_err, tcipif_bmu_dbus_data};
      default: return '0;
    endcase
  endfunction

  task automatic check_quiet();
    if (bmu_biu_dbus_req || bmu_iahbl_dbus_req || bmu_tcipif_dbus_req || bmu_lsu_grnt ||
        bmu_lsu_trans_cmplt || bmu_lsu_data_vld || bmu_lsu_acc_err) begin
      report_error("handshake output high during reset");
    end
  endtask

  task automatic check_fields(bmu_target_e tgt);
    logic [70:0] got;
    logic [70:0] exp;
    exp = {lsu_bmu_addr, lsu_bmu_write, lsu_bmu_size, lsu_bmu_wdata, lsu_bmu_prot};
    case (tgt)
      tgt_biu: got = {bmu_biu_dbus_addr, bmu_biu_dbus_write, bmu_biu_dbus_size,
                      bmu_biu_dbus_wdata, bmu_biu_dbus_prot};
      tgt_iahbl: got = {bmu_iahbl_dbus_addr, bmu_iahbl_dbus_write, bmu_iahbl_dbus_size,
                        bmu_iahbl_dbus_wdata, bmu_iahbl_dbus_prot};
      default: begin
        got = {bmu_tcipif_dbus_addr, bmu_tcipif_dbus_write, bmu_tcipif_dbus_size,
               bmu_tcipif_dbus_wdata, 3'b000, bmu_tcipif_dbus_supv_mode};
        exp[3:0] = {3'b000, lsu_bmu_prot[1]};
      end
    endcase
    if (got != exp) begin
      report_error($sformatf("target %0d fields %h, expected %h", tgt, got, exp));
    end
  endtask

  task automatic check_cycle();
    bmu_target_e exp_tgt;
    logic        exp_deny;
    logic [2:0]  got_req;
    logic [35:0] resp;
    exp_tgt = expect_target(lsu_bmu_addr);
    exp_deny = expect_deny(lsu_bmu_addr, lsu_bmu_size, lsu_bmu_prot, lsu_bmu_addr_check_fail);
    got_req = {bmu_tcipif_dbus_req, bmu_iahbl_dbus_req, bmu_biu_dbus_req};
    grant_seen = 1'b0;
    checks++;
    if (m_out) begin
      if (got_req != 3'b000 || bmu_lsu_grnt) begin
        report_error($sformatf("req %b grnt %b while a transfer is outstanding",
                               got_req, bmu_lsu_grnt));
      end
      if (m_deny) begin
        if (!bmu_lsu_trans_cmplt || !bmu_lsu_acc_err || bmu_lsu_data_vld) begin
          report_error("denied request did not end with an access error one cycle later");
        end
        m_out = 1'b0;
      end else begin
        resp = target_response(m_tgt);
        if (bmu_lsu_trans_cmplt != resp[34]) begin
          report_error($sformatf("trans_cmplt %b, target drives %b",
                                 bmu_lsu_trans_cmplt, resp[34]));
        end
        if (resp[34]) begin
          if ({bmu_lsu_data_vld, bmu_lsu_acc_err, bmu_lsu_data} != resp[33:0]) begin
            report_error($sformatf("response %h, expected %h",
                                   {bmu_lsu_data_vld, bmu_lsu_acc_err, bmu_lsu_data},
                                   resp[33:0]));
          end
          m_out = 1'b0;
        end
      end
    end else begin
      if (bmu_lsu_trans_cmplt || bmu_lsu_data_vld || bmu_lsu_acc_err) begin
        report_error("response outputs high with no transfer outstanding");
      end
      if (!lsu_bmu_req) begin
        if (got_req != 3'b000 || bmu_lsu_grnt) begin
          report_error("target req or grant with no load/store request");
        end
      end else if (exp_deny) begin
        if (got_req != 3'b000 || !bmu_lsu_grnt) begin
          report_error($sformatf("denied request at %h gave req %b grnt %b",
                                 lsu_bmu_addr, got_req, bmu_lsu_grnt));
        end
        grant_seen = 1'b1;
        m_deny = 1'b1;
        m_out = 1'b1;
        granted++;
      end else begin
        if (got_req != (3'b001 << exp_tgt)) begin
          report_error($sformatf("address %h gave req %b, expected target %0d",
                                 lsu_bmu_addr, got_req, exp_tgt));
        end
        check_fields(exp_tgt);
        resp = target_response(exp_tgt);
        if (bmu_lsu_grnt != resp[35]) begin
          report_error($sformatf("grnt %b, target drives %b", bmu_lsu_grnt, resp[35]));
        end
        if (resp[35]) begin
          grant_seen = 1'b1;
          m_deny = 1'b0;
          m_tgt = exp_tgt;
          m_out = 1'b1;
          granted++;
        end
      end
    end
  endtask

  // a third of the addresses each go to the private segment, the pin window and anywhere
  task automatic new_request();
    logic [31:0] a;
    int          mode;
    mode = rand_below(3);
    a = $random(seed);
    if (mode == 0) begin
      a[31:28] = 4'he;
    end else if (mode == 1) begin
      a[31:20] = (pad_bmu_iahbl_base & pad_bmu_iahbl_mask) | (a[31:20] & ~pad_bmu_iahbl_mask);
    end
    if (rand_below(4) != 0) begin
      a[1:0] = 2'b00;
    end
    lsu_bmu_req <= 1'b1;
    lsu_bmu_addr <= a;
    lsu_bmu_write <= 1'($random(seed));
    lsu_bmu_size <= (rand_below(8) == 0) ? 2'd3 : 2'(rand_below(3));
    lsu_bmu_prot <= 4'($random(seed));
    lsu_bmu_wdata <= $random(seed);
    lsu_bmu_addr_check_fail <= (rand_below(10) == 0);
    issued++;
  endtask

  always @(posedge forever_cpuclk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("the run timed out after %0d cycles with %0d requests granted", cycles, granted);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    int i;
    rst = 1'b1;
    lsu_bmu_req = 1'b0;
    lsu_bmu_addr = '0;
    lsu_bmu_write = 1'b0;
    lsu_bmu_size = '0;
    lsu_bmu_prot = '0;
    lsu_bmu_wdata = '0;
    lsu_bmu_addr_check_fail = 1'b0;
    // the window covers segments 6 and e, so half of its pages also lie in the private segment
    pad_bmu_iahbl_base = {4'he, 8'($random(seed))};
    pad_bmu_iahbl_mask = {4'h7, 8'($random(seed))};
    for (i = 0; i < 8; i++) begin
      @(posedge forever_cpuclk);
      if (i == 7) begin
        rst <= 1'b0;
      end
      @(negedge forever_cpuclk);
      check_quiet();
    end
    while (granted < n_req || m_out) begin
      @(posedge forever_cpuclk);
      if (grant_seen || !lsu_bmu_req) begin
        if (issued < n_req && (!grant_seen || rand_below(2) == 0)) begin
          new_request();
        end else begin
          lsu_bmu_req <= 1'b0;
        end
      end
      @(negedge forever_cpuclk);
      check_cycle();
    end
    $display("%0d cycles checked, %0d requests granted, %0d errors", checks, granted, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* hdl/bmu_access_check.sv */
module bmu_access_check (
  input  bmu_bus_pkg::bmu_addr_u          addr,
  input  logic [bmu_bus_pkg::size_w-1:0]  size,
  input  logic [bmu_bus_pkg::prot_w-1:0]  prot,
  input  logic                            addr_check_fail,
  output logic                            deny
);

  import bmu_bus_pkg::*;
  import bmu_map_pkg::*;

  logic misalign;
  logic bad_size;
  logic user_ppa;

  always_comb begin
    misalign = 1'b0;
    bad_size = 1'b0;
    case (size)
      size_byte: misalign = 1'b0;
      size_half: misalign = addr[0];
      size_word: misalign = (addr[1:0] != 2'b00);
      default:   bad_size = 1'b1;
    endcase
  end

  // user mode may not touch the private peripheral segment
  assign user_ppa = !prot[prot_priv_bit] && (addr.sg.seg == tcip_seg);

  assign deny = bad_size || misalign || user_ppa || addr_check_fail;

endmodule

/* hdl/bmu_bus_pkg.sv */
package bmu_bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int prot_w = 4;
  localparam int size_w = 2;

  // the iahbl page is the top of the address and sets the pad base/mask width
  localparam int page_w = 12;
  localparam int seg_w  = 4;

  // code 3 is not a legal transfer size
  localparam logic [size_w-1:0] size_byte = 2'd0;
  localparam logic [size_w-1:0] size_half = 2'd1;
  localparam logic [size_w-1:0] size_word = 2'd2;

  localparam int prot_priv_bit = 1;

  // one address word seen either as page/offset or as segment/rest
  typedef union packed {
    struct packed {
      logic [page_w-1:0]        page;
      logic [addr_w-page_w-1:0] offset;
    } pg;
    struct packed {
      logic [seg_w-1:0]        seg;
      logic [addr_w-seg_w-1:0] rest;
    } sg;
  } bmu_addr_u;

endpackage

/* hdl/bmu_dbus_route.sv */
module bmu_dbus_route (
  input  logic                            forever_cpuclk,
  input  logic                            rst,
  input  logic                            lsu_bmu_req,
  input  logic [bmu_bus_pkg::addr_w-1:0]  lsu_bmu_addr,
  input  logic                            lsu_bmu_write,
  input  logic [bmu_bus_pkg::size_w-1:0]  lsu_bmu_size,
  input  logic [bmu_bus_pkg::prot_w-1:0]  lsu_bmu_prot,
  input  logic [bmu_bus_pkg::data_w-1:0]  lsu_bmu_wdata,
  input  bmu_map_pkg::bmu_target_e        target,
  input  logic                            deny,
  output logic                            bmu_lsu_grnt,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_lsu_data,
  output logic                            bmu_lsu_data_vld,
  output logic                            bmu_lsu_acc_err,
  output logic                            bmu_lsu_trans_cmplt,
  output logic                            bmu_biu_dbus_req,
  output logic [bmu_bus_pkg::addr_w-1:0]  bmu_biu_dbus_addr,
  output logic                            bmu_biu_dbus_write,
  output logic [bmu_bus_pkg::size_w-1:0]  bmu_biu_dbus_size,
  output logic [bmu_bus_pkg::prot_w-1:0]  bmu_biu_dbus_prot,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_biu_dbus_wdata,
  input  logic                            biu_bmu_dbus_grnt,
  input  logic [bmu_bus_pkg::data_w-1:0]  biu_bmu_dbus_data,
  input  logic                            biu_bmu_dbus_data_vld,
  input  logic                            biu_bmu_dbus_acc_err,
  input  logic                            biu_bmu_dbus_trans_cmplt,
  output logic                            bmu_iahbl_dbus_req,
  output logic [bmu_bus_pkg::addr_w-1:0]  bmu_iahbl_dbus_addr,
  output logic                            bmu_iahbl_dbus_write,
  output logic [bmu_bus_pkg::size_w-1:0]  bmu_iahbl_dbus_size,
  output logic [bmu_bus_pkg::prot_w-1:0]  bmu_iahbl_dbus_prot,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_iahbl_dbus_wdata,
  input  logic                            iahbl_bmu_dbus_grnt,
  input  logic [bmu_bus_pkg::data_w-1:0]  iahbl_bmu_dbus_data,
  input  logic                            iahbl_bmu_dbus_data_vld,
  input  logic                            iahbl_bmu_dbus_acc_err,
  input  logic                            iahbl_bmu_dbus_trans_cmplt,
  output logic                            bmu_tcipif_dbus_req,
  output logic [bmu_bus_pkg::addr_w-1:0]  bmu_tcipif_dbus_addr,
  output logic                            bmu_tcipif_dbus_write,
  output logic [bmu_bus_pkg::size_w-1:0]  bmu_tcipif_dbus_size,
  output logic                            bmu_tcipif_dbus_supv_mode,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_tcipif_dbus_wdata,
  input  logic                            tcipif_bmu_dbus_grnt,
  input  logic [bmu_bus_pkg::data_w-1:0]  tcipif_bmu_dbus_data,
  input  logic                            tcipif_bmu_dbus_data_vld,
  input  logic                            tcipif_bmu_dbus_acc_err,
  input  logic                            tcipif_bmu_dbus_trans_cmplt
);

  import bmu_bus_pkg::*;
  import bmu_map_pkg::*;

  logic        out_vld;
  bmu_target_e out_tgt;
  logic        issue;
  logic        tgt_grnt;

  // nothing goes out while a transfer is still in flight
  assign issue = lsu_bmu_req && !out_vld;

  always_comb begin
    case (target)
      tgt_biu:   tgt_grnt = biu_bmu_dbus_grnt;
      tgt_iahbl: tgt_grnt = iahbl_bmu_dbus_grnt;
      tgt_tcip:  tgt_grnt = tcipif_bmu_dbus_grnt;
      default:   tgt_grnt = 1'b0;
    endcase
  end

  // a denied request is granted at once and answered locally
  assign bmu_lsu_grnt = issue && (deny || tgt_grnt);

  assign bmu_biu_dbus_req    = issue && !deny && (target == tgt_biu);
  assign bmu_iahbl_dbus_req  = issue && !deny && (target == tgt_iahbl);
  assign bmu_tcipif_dbus_req = issue && !deny && (target == tgt_tcip);

  assign bmu_biu_dbus_addr  = lsu_bmu_addr;
  assign bmu_biu_dbus_write = lsu_bmu_write;
  assign bmu_biu_dbus_size  = lsu_bmu_size;
  assign bmu_biu_dbus_prot  = lsu_bmu_prot;
  assign bmu_biu_dbus_wdata = lsu_bmu_wdata;

  assign bmu_iahbl_dbus_addr  = lsu_bmu_addr;
  assign bmu_iahbl_dbus_write = lsu_bmu_write;
  assign bmu_iahbl_dbus_size  = lsu_bmu_size;
  assign bmu_iahbl_dbus_prot  = lsu_bmu_prot;
  assign bmu_iahbl_dbus_wdata = lsu_bmu_wdata;

  // tcipif only needs to know whether the access is privileged
  assign bmu_tcipif_dbus_addr      = lsu_bmu_addr;
  assign bmu_tcipif_dbus_write     = lsu_bmu_write;
  assign bmu_tcipif_dbus_size      = lsu_bmu_size;
  assign bmu_tcipif_dbus_supv_mode = lsu_bmu_prot[prot_priv_bit];
  assign bmu_tcipif_dbus_wdata     = lsu_bmu_wdata;

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      out_vld <= 1'b0;
      out_tgt <= tgt_biu;
    end else if (bmu_lsu_grnt) begin
      out_vld <= 1'b1;
      out_tgt <= deny ? tgt_deny : target;
    end else if (bmu_lsu_trans_cmplt) begin
      out_vld <= 1'b0;
    end
  end

  // the recorded target owns the response path until it completes
  always_comb begin
    bmu_lsu_data        = '0;
    bmu_lsu_data_vld    = 1'b0;
    bmu_lsu_acc_err     = 1'b0;
    bmu_lsu_trans_cmplt = 1'b0;
    if (out_vld) begin
      case (out_tgt)
        tgt_biu: begin
          bmu_lsu_data        = biu_bmu_dbus_data;
          bmu_lsu_data_vld    = biu_bmu_dbus_data_vld;
          bmu_lsu_acc_err     = biu_bmu_dbus_acc_err;
          bmu_lsu_trans_cmplt = biu_bmu_dbus_trans_cmplt;
        end
        tgt_iahbl: begin
          bmu_lsu_data        = iahbl_bmu_dbus_data;
          bmu_lsu_data_vld    = iahbl_bmu_dbus_data_vld;
          bmu_lsu_acc_err     = iahbl_bmu_dbus_acc_err;
          bmu_lsu_trans_cmplt = iahbl_bmu_dbus_trans_cmplt;
        end
        tgt_tcip: begin
          bmu_lsu_data        = tcipif_bmu_dbus_data;
          bmu_lsu_data_vld    = tcipif_bmu_dbus_data_vld;
          bmu_lsu_acc_err     = tcipif_bmu_dbus_acc_err;
          bmu_lsu_trans_cmplt = tcipif_bmu_dbus_trans_cmplt;
        end
        default: begin
          bmu_lsu_acc_err     = 1'b1;
          bmu_lsu_trans_cmplt = 1'b1;
        end
      endcase
    end
  end

endmodule

/* hdl/bmu_map_pkg.sv */
package bmu_map_pkg;

  // tgt_deny never comes out of the decoder and marks a locally denied transfer
  typedef enum logic [1:0] {
    tgt_biu   = 2'd0,
    tgt_iahbl = 2'd1,
    tgt_tcip  = 2'd2,
    tgt_deny  = 2'd3
  } bmu_target_e;

  // private peripheral segment, served by the tightly coupled ip interface
  localparam logic [bmu_bus_pkg::seg_w-1:0] tcip_seg = 4'he;

endpackage

/* hdl/bmu_region_decode.sv */
module bmu_region_decode (
  input  bmu_bus_pkg::bmu_addr_u          addr,
  input  logic [bmu_bus_pkg::page_w-1:0]  iahbl_base,
  input  logic [bmu_bus_pkg::page_w-1:0]  iahbl_mask,
  output bmu_map_pkg::bmu_target_e        target
);

  import bmu_map_pkg::*;

  logic tcip_hit;
  logic iahbl_hit;

  assign tcip_hit = (addr.sg.seg == tcip_seg);

  // only the page bits set in the mask take part in the compare
  assign iahbl_hit = ((addr.pg.page & iahbl_mask) == (iahbl_base & iahbl_mask));

  // the private segment wins even when the iahbl window overlaps it
  always_comb begin
    if (tcip_hit) begin
      target = tgt_tcip;
    end else if (iahbl_hit) begin
      target = tgt_iahbl;
    end else begin
      target = tgt_biu;
    end
  end

endmodule

/* hdl/bmu_top.sv */
module bmu_top (
  input  logic                            forever_cpuclk,
  input  logic                            rst,
  input  logic [bmu_bus_pkg::page_w-1:0]  pad_bmu_iahbl_base,
  input  logic [bmu_bus_pkg::page_w-1:0]  pad_bmu_iahbl_mask,
  input  logic                            lsu_bmu_req,
  input  logic [bmu_bus_pkg::addr_w-1:0]  lsu_bmu_addr,
  input  logic                            lsu_bmu_write,
  input  logic [bmu_bus_pkg::size_w-1:0]  lsu_bmu_size,
  input  logic [bmu_bus_pkg::prot_w-1:0]  lsu_bmu_prot,
  input  logic [bmu_bus_pkg::data_w-1:0]  lsu_bmu_wdata,
  input  logic                            lsu_bmu_addr_check_fail,
  output logic                            bmu_lsu_grnt,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_lsu_data,
  output logic                            bmu_lsu_data_vld,
  output logic                            bmu_lsu_acc_err,
  output logic                            bmu_lsu_trans_cmplt,
  output logic                            bmu_biu_dbus_req,
  output logic [bmu_bus_pkg::addr_w-1:0]  bmu_biu_dbus_addr,
  output logic                            bmu_biu_dbus_write,
  output logic [bmu_bus_pkg::size_w-1:0]  bmu_biu_dbus_size,
  output logic [bmu_bus_pkg::prot_w-1:0]  bmu_biu_dbus_prot,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_biu_dbus_wdata,
  input  logic                            biu_bmu_dbus_grnt,
  input  logic [bmu_bus_pkg::data_w-1:0]  biu_bmu_dbus_data,
  input  logic                            biu_bmu_dbus_data_vld,
  input  logic                            biu_bmu_dbus_acc_err,
  input  logic                            biu_bmu_dbus_trans_cmplt,
  output logic                            bmu_iahbl_dbus_req,
  output logic [bmu_bus_pkg::addr_w-1:0]  bmu_iahbl_dbus_addr,
  output logic                            bmu_iahbl_dbus_write,
  output logic [bmu_bus_pkg::size_w-1:0]  bmu_iahbl_dbus_size,
  output logic [bmu_bus_pkg::prot_w-1:0]  bmu_iahbl_dbus_prot,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_iahbl_dbus_wdata,
  input  logic                            iahbl_bmu_dbus_grnt,
  input  logic [bmu_bus_pkg::data_w-1:0]  iahbl_bmu_dbus_data,
  input  logic                            iahbl_bmu_dbus_data_vld,
  input  logic                            iahbl_bmu_dbus_acc_err,
  input  logic                            iahbl_bmu_dbus_trans_cmplt,
  output logic                            bmu_tcipif_dbus_req,
  output logic [bmu_bus_pkg::addr_w-1:0]  bmu_tcipif_dbus_addr,
  output logic                            bmu_tcipif_dbus_write,
  output logic [bmu_bus_pkg::size_w-1:0]  bmu_tcipif_dbus_size,
  output logic                            bmu_tcipif_dbus_supv_mode,
  output logic [bmu_bus_pkg::data_w-1:0]  bmu_tcipif_dbus_wdata,
  input  logic                            tcipif_bmu_dbus_grnt,
  input  logic [bmu_bus_pkg::data_w-1:0]  tcipif_bmu_dbus_data,
  input  logic                            tcipif_bmu_dbus_data_vld,
  input  logic                            tcipif_bmu_dbus_acc_err,
  input  logic                            tcipif_bmu_dbus_trans_cmplt
);

  import bmu_map_pkg::*;

  bmu_target_e target;
  logic        deny;

  // the map decode and the access check look at the same request in parallel
  bmu_region_decode bmu_region_decode_inst (
    .addr       (lsu_bmu_addr),
    .iahbl_base (pad_bmu_iahbl_base),
    .iahbl_mask (pad_bmu_iahbl_mask),
    .target     (target)
  );

  bmu_access_check bmu_access_check_inst (
    .addr            (lsu_bmu_addr),
    .size            (lsu_bmu_size),
    .prot            (lsu_bmu_prot),
    .addr_check_fail (lsu_bmu_addr_check_fail),
    .deny            (deny)
  );

  // every router port has the same name as its top level port or wire
  bmu_dbus_route bmu_dbus_route_inst (.*);

endmodule

/* project.f */
hdl/bmu_bus_pkg.sv
hdl/bmu_map_pkg.sv
hdl/bmu_region_decode.sv
hdl/bmu_access_check.sv
hdl/bmu_dbus_route.sv
hdl/bmu_top.sv
bench/bmu_tb.sv
